/* src/pcie_phy_defs.svh */
`ifndef PCIE_PHY_DEFS_SVH
`define PCIE_PHY_DEFS_SVH

// Lane word geometry.
`define PHY_DATA_W 32
`define PHY_SYMS   4

// Special symbols.
`define SYM_COM   8'hBC  // K28.5, resets the Gen1 LFSR.
`define SYM_SKP   8'h1C  // K28.0, LFSR holds.
`define SYM_EIEOS 8'h00  // First symbol of a Gen3 EIEOS.

// 128b/130b sync headers.
`define SYNC_DATA 2'b10
`define SYNC_OS   2'b01

// Gen1/Gen2 LFSR seed.
`define GEN1_SEED 16'hFFFF

`endif

/* src/pcie_phy_pkg.sv */
`default_nettype none

package pcie_phy_pkg;

  // Link rate, anything below gen3 runs the 8b/10b scrambler.
  typedef enum logic [1:0] {
    gen1 = 2'd0,
    gen2 = 2'd1,
    gen3 = 2'd2,
    gen4 = 2'd3
  } rate_speed_e;

  // Gen3 per-lane LFSR seeds, indexed by lane number modulo 8.
  localparam logic [22:0] gen3_seed_lut [0:7] = '{
    23'h1DBFBC,  // Lane 0.
    23'h0607BB,
    23'h1EC760,
    23'h18C0DB,  // Lane 3.
    23'h010F12,
    23'h19CFC9,
    23'h0277CE,
    23'h1BB807   // Lane 7.
  };

endpackage

`default_nettype wire

/* src/pcie_lane_pkg.sv */
`default_nettype none

`include "pcie_phy_defs.svh"

package pcie_lane_pkg;

  // Four-symbol word, symbol 0 in data[7:0] and k[0].
  typedef struct packed {
    logic [`PHY_DATA_W-1:0] data;
    logic [`PHY_SYMS-1:0]   k;     // One control flag per symbol.
  } lane_word_t;

  // 128b/130b block sideband.
  typedef struct packed {
    logic [1:0] sync_header;
    logic       block_start;  // First word of a block.
  } block_ctrl_t;

endpackage

`default_nettype wire

/* src/gen1_scramble.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pcie_phy_defs.svh"

module gen1_scramble (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       valid_i,
  input  wire pcie_lane_pkg::lane_word_t  word_i,
  output logic                            valid_o,
  output pcie_lane_pkg::lane_word_t       word_o
);

  import pcie_lane_pkg::*;

  logic [15:0] lfsr_q;
  logic [15:0] lfsr_d;
  lane_word_t  word_d;

  // Eight Galois steps of x^16+x^5+x^4+x^3+1.
  function automatic logic [15:0] lfsr_adv8(input logic [15:0] state);
    logic [15:0] s;
    s = state;
    for (int i = 0; i < 8; i++) begin
      s = {s[14:0], 1'b0} ^ (s[15] ? 16'h0039 : 16'h0000);
    end
    return s;
  endfunction

  // Key byte, data bit i meets lfsr bit 15-i.
  function automatic logic [7:0] key_byte(input logic [15:0] state);
    logic [7:0] key;
    for (int i = 0; i < 8; i++) begin
      key[i] = state[15-i];
    end
    return key;
  endfunction

  // Symbols 0 to 3 in order, each stage sees the previous LFSR state.
  always_comb begin
    lfsr_d = lfsr_q;
    word_d = word_i;
    for (int s = 0; s < `PHY_SYMS; s++) begin
      if (word_i.k[s]) begin
        if (word_i.data[8*s +: 8] == `SYM_COM) begin
          lfsr_d = `GEN1_SEED;  // COM goes out clear, then reseeds.
        end else if (word_i.data[8*s +: 8] != `SYM_SKP) begin
          lfsr_d = lfsr_adv8(lfsr_d);
        end
      end else begin
        word_d.data[8*s +: 8] = word_i.data[8*s +: 8] ^ key_byte(lfsr_d);
        lfsr_d = lfsr_adv8(lfsr_d);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q  <= `GEN1_SEED;
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        lfsr_q <= lfsr_d;  // Holds while idle or unselected.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      word_o <= word_d;
    end
  end

endmodule

`default_nettype wire

/* src/gen3_scramble.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pcie_phy_defs.svh"

module gen3_scramble (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       valid_i,
  input  wire logic [7:0]                 lane_number_i,
  input  wire pcie_lane_pkg::lane_word_t  word_i,
  input  wire pcie_lane_pkg::block_ctrl_t ctrl_i,
  output logic                            valid_o,
  output pcie_lane_pkg::lane_word_t       word_o
);

  import pcie_phy_pkg::*;
  import pcie_lane_pkg::*;

  logic [22:0] lfsr_q;
  logic [22:0] lfsr_d;
  logic [22:0] lane_seed;
  logic        blk_start;
  logic        data_blk;
  logic        data_blk_q;
  logic        eieos_blk;
  lane_word_t  word_d;

  // Serial x^23+x^21+x^16+x^8+x^5+x^2+1, bit 0 first.
  function automatic logic [31:0] scramble32(
    input  logic [22:0] state,
    input  logic [31:0] din,
    output logic [22:0] state_o
  );
    logic [22:0] s;
    logic [31:0] dout;
    s = state;
    for (int i = 0; i < 32; i++) begin
      dout[i] = din[i] ^ s[22];
      s = {s[21:0], 1'b0} ^ (s[22] ? 23'h210125 : 23'h000000);
    end
    state_o = s;
    return dout;
  endfunction

  assign lane_seed = gen3_seed_lut[lane_number_i[2:0]];
  assign blk_start = valid_i && ctrl_i.block_start;

  // Block type latches on the first word, later words follow it.
  assign data_blk  = blk_start ? (ctrl_i.sync_header == `SYNC_DATA) : data_blk_q;
  assign eieos_blk = blk_start && (ctrl_i.sync_header == `SYNC_OS) &&
                     (word_i.data[7:0] == `SYM_EIEOS);

  always_comb begin
    lfsr_d      = lfsr_q;
    word_d.data = word_i.data;
    word_d.k    = '0;  // No K symbols in 128b/130b.
    if (data_blk) begin
      word_d.data = scramble32(lfsr_q, word_i.data, lfsr_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q     <= lane_seed;
      data_blk_q <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        data_blk_q <= data_blk;
        // OS blocks hold the LFSR, so the reseed shows in the next block.
        lfsr_q     <= eieos_blk ? lane_seed : lfsr_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      word_o <= word_d;
    end
  end

endmodule

`default_nettype wire

/* src/scrambler.sv */
`timescale 1ns/1ns
`default_nettype none

module scrambler (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic [7:0]                 lane_number_i,
  input  wire pcie_phy_pkg::rate_speed_e  rate_i,
  input  wire logic                       valid_i,
  input  wire pcie_lane_pkg::lane_word_t  word_i,
  input  wire pcie_lane_pkg::block_ctrl_t ctrl_i,
  output logic                            valid_o,
  output pcie_lane_pkg::lane_word_t       word_o,
  output pcie_lane_pkg::block_ctrl_t      ctrl_o
);

  import pcie_phy_pkg::*;
  import pcie_lane_pkg::*;

  logic       use_gen3;
  logic       sel_gen3_q;
  lane_word_t gen1_word;
  lane_word_t gen3_word;

  assign use_gen3 = (rate_i >= gen3);

  // Only the selected core advances its LFSR.
  gen1_scramble u_gen1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i && !use_gen3),
    .word_i  (word_i),
    .valid_o (),
    .word_o  (gen1_word)
  );

  gen3_scramble u_gen3 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (valid_i && use_gen3),
    .lane_number_i (lane_number_i),
    .word_i        (word_i),
    .ctrl_i        (ctrl_i),
    .valid_o       (),
    .word_o        (gen3_word)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_gen3_q <= 1'b0;
      valid_o    <= 1'b0;
      ctrl_o     <= '0;
    end else begin
      sel_gen3_q <= use_gen3;  // Lines up with the core registers.
      valid_o    <= valid_i;
      ctrl_o     <= ctrl_i;
    end
  end

  assign word_o = sel_gen3_q ? gen3_word : gen1_word;

endmodule

`default_nettype wire

/* src/scramble_loop_top.sv */
`timescale 1ns/1ns
`default_nettype none

module scramble_loop_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic [7:0]                 lane_number_i,
  input  wire pcie_phy_pkg::rate_speed_e  rate_i,
  input  wire logic                       valid_i,
  input  wire pcie_lane_pkg::lane_word_t  word_i,
  input  wire pcie_lane_pkg::block_ctrl_t ctrl_i,
  output logic                            tx_valid_o,
  output pcie_lane_pkg::lane_word_t       tx_word_o,
  output pcie_lane_pkg::block_ctrl_t      tx_ctrl_o,
  output logic                            rx_valid_o,
  output pcie_lane_pkg::lane_word_t       rx_word_o,
  output pcie_lane_pkg::block_ctrl_t      rx_ctrl_o
);

  scrambler tx_scrambler (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_number_i (lane_number_i),
    .rate_i        (rate_i),
    .valid_i       (valid_i),
    .word_i        (word_i),
    .ctrl_i        (ctrl_i),
    .valid_o       (tx_valid_o),
    .word_o        (tx_word_o),
    .ctrl_o        (tx_ctrl_o)
  );

  // Same LFSR sequence again, XOR restores the original word.
  scrambler rx_descrambler (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_number_i (lane_number_i),
    .rate_i        (rate_i),
    .valid_i       (tx_valid_o),
    .word_i        (tx_word_o),
    .ctrl_i        (tx_ctrl_o),
    .valid_o       (rx_valid_o),
    .word_o        (rx_word_o),
    .ctrl_o        (rx_ctrl_o)
  );

endmodule

`default_nettype wire

/* tb/scramble_assert.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pcie_phy_defs.svh"

module scramble_assert (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic [7:0]                 lane_number_i,
  input  wire pcie_phy_pkg::rate_speed_e  rate_i,
  input  wire logic                       valid_i,
  input  wire pcie_lane_pkg::lane_word_t  word_i,
  input  wire pcie_lane_pkg::block_ctrl_t ctrl_i,
  input  wire logic                       tx_valid_i,
  input  wire pcie_lane_pkg::lane_word_t  tx_word_i,
  input  wire pcie_lane_pkg::block_ctrl_t tx_ctrl_i,
  input  wire logic                       rx_valid_i,
  input  wire pcie_lane_pkg::lane_word_t  rx_word_i,
  input  wire pcie_lane_pkg::block_ctrl_t rx_ctrl_i
);

  import pcie_phy_pkg::*;
  import pcie_lane_pkg::*;

  localparam logic [22:0] lane_seeds [0:7] = '{
    23'h1DBFBC, 23'h0607BB, 23'h1EC760, 23'h18C0DB,
    23'h010F12, 23'h19CFC9, 23'h0277CE, 23'h1BB807
  };

  int unsigned fail_cnt;
  logic        is_gen3;
  logic        g3_data;
  logic        g3_data_q;
  logic        g3_eieos;
  logic        seen_valid;
  logic [15:0] g1_q;
  logic [15:0] g1_next;
  logic [22:0] g3_q;
  logic [22:0] g3_next;
  lane_word_t  g1_word;
  lane_word_t  g3_word;
  lane_word_t  exp_tx_word;
  lane_word_t  word_d1;
  lane_word_t  word_d2;
  block_ctrl_t ctrl_d1;
  block_ctrl_t ctrl_d2;
  logic        valid_d1;
  logic        valid_d2;

  // Bit-serial Gen1 reference. The key bit is the LFSR MSB before each step.
  function automatic lane_word_t gen1_model(input logic [15:0] state, input lane_word_t w,
                                            output logic [15:0] state_o);
    lane_word_t  r;
    logic [15:0] st;
    logic [7:0]  sym;
    r  = w;
    st = state;
    for (int s = 0; s < `PHY_SYMS; s++) begin
      sym = w.data[8*s +: 8];
      if (w.k[s] && sym == `SYM_COM) begin
        st = `GEN1_SEED;
      end else if (!(w.k[s] && sym == `SYM_SKP)) begin
        for (int b = 0; b < 8; b++) begin
          if (!w.k[s]) r.data[8*s+b] = sym[b] ^ st[15];
          st = {st[14:0], 1'b0} ^ ({16{st[15]}} & 16'h0039);  // x^16+x^5+x^4+x^3+1.
        end
      end
    end
    state_o = st;
    return r;
  endfunction

  function automatic logic [31:0] gen3_model(input logic [22:0] state, input logic [31:0] din,
                                             output logic [22:0] state_o);
    logic [22:0] st;
    logic [31:0] dout;
    st = state;
    for (int b = 0; b < 32; b++) begin
      dout[b] = din[b] ^ st[22];
      st = {st[21:0], 1'b0} ^ ({23{st[22]}} & 23'h210125);  // x^23+x^21+x^16+x^8+x^5+x^2+1.
    end
    state_o = st;
    return dout;
  endfunction

  always_comb begin
    is_gen3      = (rate_i >= gen3);
    g1_word      = gen1_model(g1_q, word_i, g1_next);
    g3_data      = (valid_i && ctrl_i.block_start) ? (ctrl_i.sync_header == `SYNC_DATA)
                                                   : g3_data_q;
    g3_eieos     = valid_i && ctrl_i.block_start && (ctrl_i.sync_header == `SYNC_OS) &&
                   (word_i.data[7:0] == `SYM_EIEOS);
    g3_next      = g3_q;
    g3_word.data = word_i.data;
    g3_word.k    = 4'b0000;
    if (g3_data) g3_word.data = gen3_model(g3_q, word_i.data, g3_next);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      g1_q       <= `GEN1_SEED;
      g3_q       <= lane_seeds[lane_number_i[2:0]];  // Lane modulo 8.
      g3_data_q  <= 1'b0;
      seen_valid <= 1'b0;
      valid_d1   <= 1'b0;
      valid_d2   <= 1'b0;
      ctrl_d1    <= '0;
      ctrl_d2    <= '0;
    end else begin
      seen_valid <= seen_valid || valid_i;
      valid_d1   <= valid_i;
      valid_d2   <= valid_d1;
      ctrl_d1    <= ctrl_i;
      ctrl_d2    <= ctrl_d1;
      if (valid_i && !is_gen3) g1_q <= g1_next;
      if (valid_i && is_gen3) begin
        g3_q      <= g3_eieos ? lane_seeds[lane_number_i[2:0]] : g3_next;
        g3_data_q <= g3_data;
      end
      if (valid_i) begin
        exp_tx_word <= is_gen3 ? g3_word : g1_word;
        word_d1     <= '{data: word_i.data, k: (is_gen3 ? 4'b0000 : word_i.k)};
      end
      if (valid_d1) word_d2 <= word_d1;
    end
  end

  reset_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !seen_valid |-> !(tx_valid_i || rx_valid_i || tx_ctrl_i.block_start || rx_ctrl_i.block_start))
    else begin
      fail_cnt++;
      $error("FAILED reset: expected 0000 actual %b%b%b%b", tx_valid_i, rx_valid_i,
             tx_ctrl_i.block_start, rx_ctrl_i.block_start);
    end

  valid_align: assert property (@(posedge clk_i) disable iff (rst_i)
    {tx_valid_i, rx_valid_i} == {valid_d1, valid_d2})
    else begin
      fail_cnt++;
      $error("FAILED valid: expected %b%b actual %b%b", valid_d1, valid_d2, tx_valid_i, rx_valid_i);
    end

  tx_ctrl_align: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_ctrl_i == ctrl_d1)
    else begin
      fail_cnt++;
      $error("FAILED tx ctrl: expected %h actual %h", ctrl_d1, tx_ctrl_i);
    end

  tx_scramble: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_d1 |-> tx_word_i == exp_tx_word)
    else begin
      fail_cnt++;
      $error("FAILED scramble: expected %h actual %h", exp_tx_word, tx_word_i);
    end

  rx_word_loop: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_d2 |-> rx_word_i == word_d2)
    else begin
      fail_cnt++;
      $error("FAILED loopback word: expected %h actual %h", word_d2, rx_word_i);
    end

  rx_ctrl_loop: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_ctrl_i == ctrl_d2)
    else begin
      fail_cnt++;
      $error("FAILED loopback ctrl: expected %h actual %h", ctrl_d2, rx_ctrl_i);
    end

endmodule

bind scramble_loop_top scramble_assert check_u (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .lane_number_i (lane_number_i),
  .rate_i        (rate_i),
  .valid_i       (valid_i),
  .word_i        (word_i),
  .ctrl_i        (ctrl_i),
  .tx_valid_i    (tx_valid_o),
  .tx_word_i     (tx_word_o),
  .tx_ctrl_i     (tx_ctrl_o),
  .rx_valid_i    (rx_valid_o),
  .rx_word_i     (rx_word_o),
  .rx_ctrl_i     (rx_ctrl_o)
);

`default_nettype wire

/* tb/scramble_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pcie_phy_defs.svh"

module scramble_tb;

  import pcie_phy_pkg::*;
  import pcie_lane_pkg::*;

  localparam int max_cycles = 2000;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [7:0]  lane_number_i;
  rate_speed_e rate_i;
  logic        valid_i;
  lane_word_t  word_i;
  block_ctrl_t ctrl_i;
  logic        tx_valid_o;
  lane_word_t  tx_word_o;
  block_ctrl_t tx_ctrl_o;
  logic        rx_valid_o;
  lane_word_t  rx_word_o;
  block_ctrl_t rx_ctrl_o;
  integer      seed;
  int          cycle_cnt;

  scramble_loop_top uut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_number_i (lane_number_i),
    .rate_i        (rate_i),
    .valid_i       (valid_i),
    .word_i        (word_i),
    .ctrl_i        (ctrl_i),
    .tx_valid_o    (tx_valid_o),
    .tx_word_o     (tx_word_o),
    .tx_ctrl_o     (tx_ctrl_o),
    .rx_valid_o    (rx_valid_o),
    .rx_word_o     (rx_word_o),
    .rx_ctrl_o     (rx_ctrl_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("test failed");
      $fatal(1, "Timeout, the stimulus did not finish within %0d cycles.", max_cycles);
    end
  end

  always @(negedge clk_i) begin
    if (uut.check_u.fail_cnt != 0) begin
      $display("test failed");
      $fatal(1, "A checker assertion fired.");
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      valid_i            = 1'b0;
      ctrl_i.block_start = 1'b0;
    end
  endtask

  // Up to max_gap random idle cycles ahead of the word.
  task automatic send_word(input logic [31:0] data, input logic [3:0] k,
                           input logic [1:0] sync, input logic start, input int max_gap);
    int gap;
    gap = (max_gap > 0) ? ({$random(seed)} % (max_gap + 1)) : 0;
    idle(gap);
    @(negedge clk_i);
    valid_i = 1'b1;
    word_i  = '{data: data, k: k};
    ctrl_i  = '{sync_header: sync, block_start: start};
  endtask

  task automatic gen1_burst(input int n, input int max_gap);
    logic [31:0] data;
    logic [31:0] r;
    logic [3:0]  k;
    for (int i = 0; i < n; i++) begin
      data = $random(seed);
      r    = $random(seed);
      k    = 4'b0000;
      if (r[2:0] == 3'd0) begin
        data[8*r[4:3] +: 8] = `SYM_COM;
        k[r[4:3]]           = 1'b1;
      end
      if (r[6:5] == 2'd0) begin
        data[8*r[8:7] +: 8] = `SYM_SKP;
        k[r[8:7]]           = 1'b1;
      end
      if (r[11:9] == 3'd0) begin
        data[8*r[13:12] +: 8] = 8'hFB;  // STP is an ordinary K symbol.
        k[r[13:12]]           = 1'b1;
      end
      send_word(data, k, `SYNC_DATA, 1'b0, max_gap);
    end
  endtask

  task automatic gen3_block(input logic [1:0] sync, input logic [7:0] first_sym,
                            input int nwords, input int max_gap);
    logic [31:0] data;
    logic [31:0] r;
    for (int i = 0; i < nwords; i++) begin
      data = $random(seed);
      r    = $random(seed);
      if (i == 0 && sync == `SYNC_OS) data[7:0] = first_sym;
      send_word(data, r[3:0], sync, (i == 0), max_gap);  // Gen3 drops these K flags.
    end
  endtask

  // EIEOS, data, plain OS, data, EIEOS, data restarting from the seed.
  task automatic gen3_sequence(input int max_gap);
    gen3_block(`SYNC_OS, `SYM_EIEOS, 4, max_gap);
    gen3_block(`SYNC_DATA, 8'h00, 4, max_gap);
    gen3_block(`SYNC_OS, 8'hE1, 2, max_gap);
    gen3_block(`SYNC_DATA, 8'h00, 4, max_gap);
    gen3_block(`SYNC_OS, `SYM_EIEOS, 4, max_gap);
    gen3_block(`SYNC_DATA, 8'h00, 4, max_gap);
  endtask

  // Both scramblers must drain before rate or lane moves.
  task automatic switch_rate(input rate_speed_e rate, input logic [7:0] lane);
    idle(3);
    rate_i        = rate;
    lane_number_i = lane;
    idle(2);
  endtask

  initial begin
    seed          = 32'hb0d18753;
    rst_i         = 1'b1;
    lane_number_i = 8'd0;
    rate_i        = gen1;
    valid_i       = 1'b0;
    word_i        = '0;
    ctrl_i        = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    idle(5);
    gen1_burst(200, 0);
    switch_rate(gen3, 8'd0);
    gen3_sequence(0);
    switch_rate(gen3, 8'd3);
    gen3_sequence(0);
    switch_rate(gen3, 8'd9);  // Same seed as lane 1.
    gen3_sequence(0);
    switch_rate(gen1, 8'd2);
    gen1_burst(60, 3);
    switch_rate(gen2, 8'd2);
    gen1_burst(60, 3);
    switch_rate(gen3, 8'd2);
    gen3_sequence(3);
    switch_rate(gen4, 8'd2);
    gen3_sequence(3);
    switch_rate(gen1, 8'd5);
    gen1_burst(40, 1);
    switch_rate(gen3, 8'd5);
    gen3_sequence(1);
    switch_rate(gen1, 8'd5);  // Gen1 picks up its held LFSR.
    gen1_burst(40, 1);
    idle(5);
    if (uut.check_u.fail_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "Assertion failures were recorded.");
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/pcie_phy_pkg.sv
src/pcie_lane_pkg.sv
src/gen1_scramble.sv
src/gen3_scramble.sv
src/scrambler.sv
src/scramble_loop_top.sv
tb/scramble_assert.sv
tb/scramble_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module scramble_tb -f vlog.f &&
  ./obj_dir/Vscramble_tb +verilator+error+limit+100 ||
  { echo "simulation run did not pass"; exit 1; }
